/* logic/blinky_pkg.sv */
package blinky_pkg;

  // bus geometry
  localparam int DATA_W   = 32;
  localparam int STRB_W   = DATA_W / 8;
  // byte address to word index
  localparam int ADDR_LSB = 2;

  // AXI-Lite response codes
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } axil_resp_e;

  // register map, as word indices
  typedef enum logic [2:0] {
    REG_FLAGS      = 3'd0,
    REG_CNT_TOGGLE = 3'd1,
    REG_CLOCK_FREQ = 3'd2,
    REG_CNT        = 3'd3,
    REG_LED        = 3'd4
  } reg_idx_e;

  // led sequencer modes
  typedef enum logic [1:0] {
    LED_OFF   = 2'd0,
    LED_SOLID = 2'd1,
    LED_BLINK = 2'd2
  } led_state_e;

endpackage

/* logic/skid_buffer.sv */
`timescale 1ns/1ps

// two-entry buffer for one valid/ready channel
// the main register feeds the output, the skid register catches
// the beat that arrives while the output is stalled
module skid_buffer #(
  parameter int WIDTH = 8
) (
  input  logic             clk,
  input  logic             rst_n,

  input  logic             i_valid,
  input  logic [WIDTH-1:0] i_data,
  output logic             o_ready,

  output logic             o_valid,
  output logic [WIDTH-1:0] o_data,
  input  logic             i_ready
);

  logic             skid_valid;
  logic [WIDTH-1:0] skid_data;
  logic             in_fire;
  logic             main_free;

  assign in_fire   = i_valid && o_ready;
  // main register is empty or drains on this edge
  assign main_free = !o_valid || i_ready;

  // ready comes straight from a flop, no path from i_ready
  assign o_ready = !skid_valid;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_valid    <= 1'b0;
      skid_valid <= 1'b0;
    end else if (main_free) begin
      // the skid beat is older, so it moves up first
      o_valid    <= skid_valid || in_fire;
      skid_valid <= 1'b0;
    end else if (in_fire) begin
      skid_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (main_free) begin
      o_data <= skid_valid ? skid_data : i_data;
    end
    if (!main_free && in_fire) begin
      skid_data <= i_data;
    end
  end

  // ----------------------------------------
  // checks
  // ----------------------------------------

  // a stalled beat stays on the output unchanged
  a_hold_stalled: assert property (@(posedge clk) disable iff (!rst_n)
    o_valid && !i_ready |=> o_valid && $stable(o_data));

endmodule

/* logic/pipelined_accumulator.sv */
`timescale 1ns/1ps

// free-running counter split in two halves
// the carry out of the low half is registered and added to the
// high half one cycle later, which keeps the add chain short
module pipelined_accumulator #(
  parameter int WIDTH = 32
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             i_clr,
  input  logic             i_en,
  output logic [WIDTH-1:0] o_acc
);

  localparam int LO_W = WIDTH / 2;
  localparam int HI_W = WIDTH - LO_W;

  logic [LO_W-1:0] acc_lo;
  logic [HI_W-1:0] acc_hi;
  logic            carry;
  logic [LO_W:0]   lo_sum;

  assign lo_sum = {1'b0, acc_lo} + 1'b1;

  always_ff @(posedge clk) begin
    if (!rst_n || i_clr) begin
      acc_lo <= '0;
      acc_hi <= '0;
      carry  <= 1'b0;
    end else begin
      // pending carry from the previous low-half wrap
      acc_hi <= acc_hi + HI_W'(carry);
      if (i_en) begin
        {carry, acc_lo} <= lo_sum;
      end else begin
        carry <= 1'b0;
      end
    end
  end

  assign o_acc = {acc_hi, acc_lo};

  // the count restarts from zero right after a clear
  a_clr_zero: assert property (@(posedge clk) disable iff (!rst_n)
    i_clr |=> o_acc == '0);

endmodule

/* logic/led_sequencer.sv */
`timescale 1ns/1ps

// decides off, solid or blinking and drives the counter clear
module led_sequencer (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        i_enable,
  input  logic        i_blink,
  input  logic [31:0] i_cnt_toggle,
  input  logic [31:0] i_cnt,
  output logic        o_cnt_clr,
  output logic        o_led
);

  blinky_pkg::led_state_e state;
  blinky_pkg::led_state_e state_next;

  always_comb begin
    if (!i_enable) begin
      state_next = blinky_pkg::LED_OFF;
    end else if (!i_blink) begin
      state_next = blinky_pkg::LED_SOLID;
    end else begin
      state_next = blinky_pkg::LED_BLINK;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= blinky_pkg::LED_OFF;
      o_led     <= 1'b0;
      o_cnt_clr <= 1'b1;
    end else begin
      state <= state_next;
      // counter held in clear unless actively blinking
      o_cnt_clr <= 1'b1;
      case (state_next)
        blinky_pkg::LED_OFF: begin
          o_led <= 1'b0;
        end
        blinky_pkg::LED_SOLID: begin
          o_led <= 1'b1;
        end
        blinky_pkg::LED_BLINK: begin
          if (state != blinky_pkg::LED_BLINK) begin
            // entering blink, start lit with a fresh count
            o_led <= 1'b1;
          end else if (i_cnt == i_cnt_toggle) begin
            o_led <= ~o_led;
          end else begin
            o_cnt_clr <= 1'b0;
          end
        end
        default: begin
          o_led <= 1'b0;
        end
      endcase
    end
  end

  // led is dark whenever the sequencer is off
  a_off_dark: assert property (@(posedge clk) disable iff (!rst_n)
    state == blinky_pkg::LED_OFF |-> !o_led);

endmodule

/* logic/blinky_regs.sv */
`timescale 1ns/1ps

// AXI-Lite register block for the blinker
//
// idx  access  contents
// 0    rw      flags, bit 0 enable, bit 1 blink
// 1    rw      cnt_toggle
// 2    ro      clock frequency
// 3    ro      live counter
// 4    ro      led level
module blinky_regs #(
  parameter int CLK_FREQ   = 100_000_000,
  parameter int ADDR_WIDTH = 8
) (
  input  logic                              clk,
  input  logic                              rst_n,

  input  logic [ADDR_WIDTH-1:0]             i_awaddr,
  input  logic                              i_awvalid,
  output logic                              o_awready,
  input  logic [blinky_pkg::DATA_W-1:0]     i_wdata,
  input  logic [blinky_pkg::STRB_W-1:0]     i_wstrb,
  input  logic                              i_wvalid,
  output logic                              o_wready,
  output logic                              o_bvalid,
  output blinky_pkg::axil_resp_e            o_bresp,
  input  logic                              i_bready,

  input  logic [ADDR_WIDTH-1:0]             i_araddr,
  input  logic                              i_arvalid,
  output logic                              o_arready,
  output logic                              o_rvalid,
  output logic [blinky_pkg::DATA_W-1:0]     o_rdata,
  output blinky_pkg::axil_resp_e            o_rresp,
  input  logic                              i_rready,

  input  logic [31:0]                       i_cnt,
  input  logic                              i_led,
  output logic                              o_enable,
  output logic                              o_blink,
  output logic [31:0]                       o_cnt_toggle
);

  localparam int DW  = blinky_pkg::DATA_W;
  localparam int SW  = blinky_pkg::STRB_W;
  localparam int RAW = ADDR_WIDTH - blinky_pkg::ADDR_LSB;

  localparam logic [DW-1:0] TOGGLE_RESET = DW'(CLK_FREQ / 2);

  // ----------------------------------------
  // write path
  // ----------------------------------------

  logic                   aw_valid;
  logic [RAW-1:0]         aw_idx;
  logic                   aw_ready;
  logic                   w_valid;
  logic [DW-1:0]          w_data;
  logic [SW-1:0]          w_strb;
  logic                   w_ready;

  logic                   bvalid_next;
  blinky_pkg::axil_resp_e bresp_next;
  logic                   enable_next;
  logic                   blink_next;
  logic [31:0]            cnt_toggle_next;

  skid_buffer #(
    .WIDTH(RAW)
  ) u_skid_aw (
    .clk    (clk),
    .rst_n  (rst_n),
    .i_valid(i_awvalid),
    .i_data (i_awaddr[ADDR_WIDTH-1:blinky_pkg::ADDR_LSB]),
    .o_ready(o_awready),
    .o_valid(aw_valid),
    .o_data (aw_idx),
    .i_ready(aw_ready)
  );

  skid_buffer #(
    .WIDTH(DW + SW)
  ) u_skid_w (
    .clk    (clk),
    .rst_n  (rst_n),
    .i_valid(i_wvalid),
    .i_data ({i_wstrb, i_wdata}),
    .o_ready(o_wready),
    .o_valid(w_valid),
    .o_data ({w_strb, w_data}),
    .i_ready(w_ready)
  );

  always_comb begin
    aw_ready        = 1'b0;
    w_ready         = 1'b0;
    bvalid_next     = o_bvalid && !i_bready;
    bresp_next      = o_bresp;
    enable_next     = o_enable;
    blink_next      = o_blink;
    cnt_toggle_next = o_cnt_toggle;

    // commit only when address, data and a free b slot line up
    if (aw_valid && w_valid && (!o_bvalid || i_bready)) begin
      aw_ready    = 1'b1;
      w_ready     = 1'b1;
      bvalid_next = 1'b1;
      bresp_next  = blinky_pkg::RESP_OKAY;

      if (w_strb != '1) begin
        // full-word writes only
        bresp_next = blinky_pkg::RESP_SLVERR;
      end else begin
        case (aw_idx)
          RAW'(blinky_pkg::REG_FLAGS): begin
            enable_next = w_data[0];
            blink_next  = w_data[1];
          end
          RAW'(blinky_pkg::REG_CNT_TOGGLE): cnt_toggle_next = w_data;
          RAW'(blinky_pkg::REG_CLOCK_FREQ): bresp_next = blinky_pkg::RESP_SLVERR;
          RAW'(blinky_pkg::REG_CNT):        bresp_next = blinky_pkg::RESP_SLVERR;
          RAW'(blinky_pkg::REG_LED):        bresp_next = blinky_pkg::RESP_SLVERR;
          default:                          bresp_next = blinky_pkg::RESP_DECERR;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_bvalid     <= 1'b0;
      o_enable     <= 1'b0;
      o_blink      <= 1'b0;
      o_cnt_toggle <= TOGGLE_RESET;
    end else begin
      o_bvalid     <= bvalid_next;
      o_enable     <= enable_next;
      o_blink      <= blink_next;
      o_cnt_toggle <= cnt_toggle_next;
    end
  end

  always_ff @(posedge clk) begin
    o_bresp <= bresp_next;
  end

  // ----------------------------------------
  // read path
  // ----------------------------------------

  logic                   ar_valid;
  logic [RAW-1:0]         ar_idx;
  logic                   ar_ready;

  logic                   rvalid_next;
  logic [DW-1:0]          rdata_next;
  blinky_pkg::axil_resp_e rresp_next;

  skid_buffer #(
    .WIDTH(RAW)
  ) u_skid_ar (
    .clk    (clk),
    .rst_n  (rst_n),
    .i_valid(i_arvalid),
    .i_data (i_araddr[ADDR_WIDTH-1:blinky_pkg::ADDR_LSB]),
    .o_ready(o_arready),
    .o_valid(ar_valid),
    .o_data (ar_idx),
    .i_ready(ar_ready)
  );

  always_comb begin
    ar_ready    = 1'b0;
    rvalid_next = o_rvalid && !i_rready;
    rdata_next  = o_rdata;
    rresp_next  = o_rresp;

    if (ar_valid && (!o_rvalid || i_rready)) begin
      ar_ready    = 1'b1;
      rvalid_next = 1'b1;
      rresp_next  = blinky_pkg::RESP_OKAY;
      rdata_next  = '0;
      case (ar_idx)
        RAW'(blinky_pkg::REG_FLAGS):      rdata_next = DW'({o_blink, o_enable});
        RAW'(blinky_pkg::REG_CNT_TOGGLE): rdata_next = o_cnt_toggle;
        RAW'(blinky_pkg::REG_CLOCK_FREQ): rdata_next = DW'(CLK_FREQ);
        RAW'(blinky_pkg::REG_CNT):        rdata_next = i_cnt;
        RAW'(blinky_pkg::REG_LED):        rdata_next = DW'(i_led);
        default:                          rresp_next = blinky_pkg::RESP_DECERR;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_rvalid <= 1'b0;
    end else begin
      o_rvalid <= rvalid_next;
    end
  end

  always_ff @(posedge clk) begin
    o_rdata <= rdata_next;
    o_rresp <= rresp_next;
  end

  // ----------------------------------------
  // checks
  // ----------------------------------------

  a_b_hold: assert property (@(posedge clk) disable iff (!rst_n)
    o_bvalid && !i_bready |=> o_bvalid && $stable(o_bresp));

  a_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
    o_rvalid && !i_rready |=> o_rvalid && $stable(o_rdata) && $stable(o_rresp));

endmodule

/* logic/blinky_top.sv */
`timescale 1ns/1ps

// memory-mapped led blinker
module blinky_top #(
  parameter int CLK_FREQ   = 100_000_000,
  parameter int ADDR_WIDTH = 8
) (
  input  logic                          clk,
  input  logic                          rst_n,

  input  logic [ADDR_WIDTH-1:0]         i_awaddr,
  input  logic                          i_awvalid,
  output logic                          o_awready,
  input  logic [blinky_pkg::DATA_W-1:0] i_wdata,
  input  logic [blinky_pkg::STRB_W-1:0] i_wstrb,
  input  logic                          i_wvalid,
  output logic                          o_wready,
  output logic                          o_bvalid,
  output blinky_pkg::axil_resp_e        o_bresp,
  input  logic                          i_bready,

  input  logic [ADDR_WIDTH-1:0]         i_araddr,
  input  logic                          i_arvalid,
  output logic                          o_arready,
  output logic                          o_rvalid,
  output logic [blinky_pkg::DATA_W-1:0] o_rdata,
  output blinky_pkg::axil_resp_e        o_rresp,
  input  logic                          i_rready,

  output logic                          o_led
);

  logic                          enable;
  logic                          blink;
  logic [blinky_pkg::DATA_W-1:0] cnt_toggle;
  logic [blinky_pkg::DATA_W-1:0] cnt;
  logic                          cnt_clr;

  blinky_regs #(
    .CLK_FREQ  (CLK_FREQ),
    .ADDR_WIDTH(ADDR_WIDTH)
  ) u_regs (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_awaddr    (i_awaddr),
    .i_awvalid   (i_awvalid),
    .o_awready   (o_awready),
    .i_wdata     (i_wdata),
    .i_wstrb     (i_wstrb),
    .i_wvalid    (i_wvalid),
    .o_wready    (o_wready),
    .o_bvalid    (o_bvalid),
    .o_bresp     (o_bresp),
    .i_bready    (i_bready),
    .i_araddr    (i_araddr),
    .i_arvalid   (i_arvalid),
    .o_arready   (o_arready),
    .o_rvalid    (o_rvalid),
    .o_rdata     (o_rdata),
    .o_rresp     (o_rresp),
    .i_rready    (i_rready),
    .i_cnt       (cnt),
    .i_led       (o_led),
    .o_enable    (enable),
    .o_blink     (blink),
    .o_cnt_toggle(cnt_toggle)
  );

  led_sequencer u_seq (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_enable    (enable),
    .i_blink     (blink),
    .i_cnt_toggle(cnt_toggle),
    .i_cnt       (cnt),
    .o_cnt_clr   (cnt_clr),
    .o_led       (o_led)
  );

  // counts every cycle, the sequencer decides when it restarts
  pipelined_accumulator #(
    .WIDTH(blinky_pkg::DATA_W)
  ) u_acc (
    .clk  (clk),
    .rst_n(rst_n),
    .i_clr(cnt_clr),
    .i_en (1'b1),
    .o_acc(cnt)
  );

endmodule

/* verif/blinky_tb.sv */
`timescale 1ns/1ps

module blinky_tb;

  localparam int CLK_FREQ   = 40;
  localparam int ADDR_WIDTH = 8;
  localparam int DW         = blinky_pkg::DATA_W;
  localparam int SW         = blinky_pkg::STRB_W;
  // toggle period out of reset, half the clock frequency
  localparam int RESET_TOGGLE = 20;
  // all tests together run for roughly 1000 cycles
  localparam int MAX_CYCLES = 4000;

  logic                   clk;
  logic                   rst_n;
  logic [ADDR_WIDTH-1:0]  awaddr;
  logic                   awvalid;
  logic                   awready;
  logic [DW-1:0]          wdata;
  logic [SW-1:0]          wstrb;
  logic                   wvalid;
  logic                   wready;
  logic                   bvalid;
  blinky_pkg::axil_resp_e bresp;
  logic                   bready;
  logic [ADDR_WIDTH-1:0]  araddr;
  logic                   arvalid;
  logic                   arready;
  logic                   rvalid;
  logic [DW-1:0]          rdata;
  blinky_pkg::axil_resp_e rresp;
  logic                   rready;
  logic                   led;

  int                     num_checks;
  int                     num_errors;
  int                     cycles;
  // register contents as the host last wrote them
  logic [1:0]             exp_flags;
  logic [DW-1:0]          exp_toggle;

  blinky_top #(
    .CLK_FREQ  (CLK_FREQ),
    .ADDR_WIDTH(ADDR_WIDTH)
  ) UUT (
    .clk      (clk),
    .rst_n    (rst_n),
    .i_awaddr (awaddr),
    .i_awvalid(awvalid),
    .o_awready(awready),
    .i_wdata  (wdata),
    .i_wstrb  (wstrb),
    .i_wvalid (wvalid),
    .o_wready (wready),
    .o_bvalid (bvalid),
    .o_bresp  (bresp),
    .i_bready (bready),
    .i_araddr (araddr),
    .i_arvalid(arvalid),
    .o_arready(arready),
    .o_rvalid (rvalid),
    .o_rdata  (rdata),
    .o_rresp  (rresp),
    .i_rready (rready),
    .o_led    (led)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, the DUT stopped responding", cycles);
      $display("checks: %0d  errors: %0d", num_checks, num_errors + 1);
      $display("*** FAILED ***");
      $finish;
    end
  end

  // ----------------------------------------
  // compare tasks
  // ----------------------------------------

  task automatic check_resp(input blinky_pkg::axil_resp_e got,
                            input blinky_pkg::axil_resp_e exp, input string what);
    num_checks++;
    if (got !== exp) begin
      num_errors++;
      $display("Mismatch at %0t: %s response %s, expected %s",
               $time, what, got.name(), exp.name());
    end
  endtask

  task automatic check_data(input logic [DW-1:0] got, input logic [DW-1:0] exp,
                            input string what);
    num_checks++;
    if (got !== exp) begin
      num_errors++;
      $display("Mismatch at %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
    end
  endtask

  task automatic check_led(input logic got, input logic exp, input string what);
    num_checks++;
    if (got !== exp) begin
      num_errors++;
      $display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // ----------------------------------------
  // AXI-Lite driver
  // ----------------------------------------

  function automatic logic [ADDR_WIDTH-1:0] word_addr(input int idx);
    return ADDR_WIDTH'(idx << blinky_pkg::ADDR_LSB);
  endfunction

  // stall is the number of cycles bready stays low once bvalid is up
  task automatic axil_write(input logic [ADDR_WIDTH-1:0] addr, input logic [DW-1:0] data,
                            input logic [SW-1:0] strb, input int stall,
                            output blinky_pkg::axil_resp_e resp);
    logic aw_go;
    logic w_go;
    bready  = (stall == 0);
    awaddr  = addr;
    awvalid = 1'b1;
    wdata   = data;
    wstrb   = strb;
    wvalid  = 1'b1;
    // ready is registered, so its value at the falling edge holds at the next rising edge
    while (awvalid || wvalid) begin
      aw_go = awvalid && awready;
      w_go  = wvalid && wready;
      @(negedge clk);
      if (aw_go) begin
        awvalid = 1'b0;
      end
      if (w_go) begin
        wvalid = 1'b0;
      end
    end
    while (!bvalid) begin
      @(negedge clk);
    end
    resp = bresp;
    for (int i = 0; i < stall; i++) begin
      @(negedge clk);
      if (!bvalid) begin
        num_errors++;
        $display("Error at %0t: bvalid dropped while bready was held low", $time);
      end
      check_resp(bresp, resp, "stalled write");
    end
    bready = 1'b1;
    @(negedge clk);
  endtask

  task automatic axil_read(input logic [ADDR_WIDTH-1:0] addr, input int stall,
                           output logic [DW-1:0] data, output blinky_pkg::axil_resp_e resp);
    rready  = (stall == 0);
    araddr  = addr;
    arvalid = 1'b1;
    while (!arready) begin
      @(negedge clk);
    end
    @(negedge clk);
    arvalid = 1'b0;
    while (!rvalid) begin
      @(negedge clk);
    end
    data = rdata;
    resp = rresp;
    for (int i = 0; i < stall; i++) begin
      @(negedge clk);
      if (!rvalid) begin
        num_errors++;
        $display("Error at %0t: rvalid dropped while rready was held low", $time);
      end
      check_data(rdata, data, "stalled rdata");
      check_resp(rresp, resp, "stalled read");
    end
    rready = 1'b1;
    @(negedge clk);
  endtask

  task automatic write_and_check(input logic [ADDR_WIDTH-1:0] addr, input logic [DW-1:0] data,
                                 input logic [SW-1:0] strb,
                                 input blinky_pkg::axil_resp_e exp, input string what);
    blinky_pkg::axil_resp_e resp;
    axil_write(addr, data, strb, 0, resp);
    check_resp(resp, exp, what);
  endtask

  // data is only meaningful on an OKAY read
  task automatic read_and_check(input logic [ADDR_WIDTH-1:0] addr, input logic [DW-1:0] exp_data,
                                input blinky_pkg::axil_resp_e exp, input string what);
    logic [DW-1:0]          data;
    blinky_pkg::axil_resp_e resp;
    axil_read(addr, 0, data, resp);
    check_resp(resp, exp, what);
    if (exp == blinky_pkg::RESP_OKAY) begin
      check_data(data, exp_data, what);
    end
  endtask

  task automatic wait_for_led(input logic exp, input int max_cycles, input string what);
    int n;
    n = 0;
    while (led !== exp && n < max_cycles) begin
      @(negedge clk);
      n++;
    end
    check_led(led, exp, what);
  endtask

  // cycles until the led level next changes
  task automatic measure_toggle_gap(output int gap);
    logic last;
    gap  = 0;
    last = led;
    do begin
      @(negedge clk);
      gap++;
    end while (led === last);
  endtask

  // ----------------------------------------
  // tests
  // ----------------------------------------

  task automatic reset_values();
    check_led(led, 1'b0, "led after reset");
    read_and_check(word_addr(blinky_pkg::REG_FLAGS), '0, blinky_pkg::RESP_OKAY, "flags");
    read_and_check(word_addr(blinky_pkg::REG_CNT_TOGGLE), DW'(RESET_TOGGLE),
                   blinky_pkg::RESP_OKAY, "cnt_toggle");
    read_and_check(word_addr(blinky_pkg::REG_CLOCK_FREQ), DW'(CLK_FREQ),
                   blinky_pkg::RESP_OKAY, "clock freq");
    // byte offset inside the word is ignored
    read_and_check(word_addr(blinky_pkg::REG_CLOCK_FREQ) | ADDR_WIDTH'(1), DW'(CLK_FREQ),
                   blinky_pkg::RESP_OKAY, "clock freq at byte offset");
    read_and_check(word_addr(blinky_pkg::REG_LED), '0, blinky_pkg::RESP_OKAY, "led reg");
  endtask

  task automatic register_readback();
    write_and_check(word_addr(blinky_pkg::REG_FLAGS), 32'ha5a5_a5a6, '1,
                    blinky_pkg::RESP_OKAY, "flags write");
    exp_flags = 2'b10;
    read_and_check(word_addr(blinky_pkg::REG_FLAGS), DW'(exp_flags),
                   blinky_pkg::RESP_OKAY, "flags readback");
    exp_toggle = $urandom;
    write_and_check(word_addr(blinky_pkg::REG_CNT_TOGGLE), exp_toggle, '1,
                    blinky_pkg::RESP_OKAY, "cnt_toggle write");
    read_and_check(word_addr(blinky_pkg::REG_CNT_TOGGLE), exp_toggle,
                   blinky_pkg::RESP_OKAY, "cnt_toggle readback");
  endtask

  task automatic error_responses();
    write_and_check(word_addr(blinky_pkg::REG_CNT_TOGGLE), 32'h55, 4'b0011,
                    blinky_pkg::RESP_SLVERR, "partial strobe");
    write_and_check(word_addr(blinky_pkg::REG_CLOCK_FREQ), 32'h1, '1,
                    blinky_pkg::RESP_SLVERR, "clock freq write");
    write_and_check(word_addr(blinky_pkg::REG_CNT), 32'h1, '1,
                    blinky_pkg::RESP_SLVERR, "counter write");
    write_and_check(word_addr(blinky_pkg::REG_LED), 32'h1, '1,
                    blinky_pkg::RESP_SLVERR, "led write");
    write_and_check(word_addr(5), 32'h3, '1, blinky_pkg::RESP_DECERR, "write at index 5");
    write_and_check(word_addr(63), 32'h3, '1, blinky_pkg::RESP_DECERR, "write at index 63");
    read_and_check(word_addr(5), '0, blinky_pkg::RESP_DECERR, "read at index 5");
    read_and_check(word_addr(40), '0, blinky_pkg::RESP_DECERR, "read at index 40");
    // nothing above may have touched the registers
    read_and_check(word_addr(blinky_pkg::REG_FLAGS), DW'(exp_flags),
                   blinky_pkg::RESP_OKAY, "flags after errors");
    read_and_check(word_addr(blinky_pkg::REG_CNT_TOGGLE), exp_toggle,
                   blinky_pkg::RESP_OKAY, "cnt_toggle after errors");
    read_and_check(word_addr(blinky_pkg::REG_CLOCK_FREQ), DW'(CLK_FREQ),
                   blinky_pkg::RESP_OKAY, "clock freq after errors");
  endtask

  task automatic solid_and_disable();
    write_and_check(word_addr(blinky_pkg::REG_FLAGS), 32'h1, '1,
                    blinky_pkg::RESP_OKAY, "enable solid");
    wait_for_led(1'b1, 3, "led in solid mode");
    read_and_check(word_addr(blinky_pkg::REG_LED), 32'h1, blinky_pkg::RESP_OKAY, "led reg");
    write_and_check(word_addr(blinky_pkg::REG_FLAGS), 32'h0, '1,
                    blinky_pkg::RESP_OKAY, "disable");
    wait_for_led(1'b0, 3, "led after disable");
    exp_flags = 2'b00;
  endtask

  task automatic blink_timing();
    int toggle;
    int gap;
    repeat (2) begin
      toggle = 8 + ($urandom % 33);
      // a new period is loaded with the counter parked, so it cannot overrun
      write_and_check(word_addr(blinky_pkg::REG_FLAGS), 32'h0, '1,
                      blinky_pkg::RESP_OKAY, "blink stop");
      write_and_check(word_addr(blinky_pkg::REG_CNT_TOGGLE), DW'(toggle), '1,
                      blinky_pkg::RESP_OKAY, "blink period");
      write_and_check(word_addr(blinky_pkg::REG_FLAGS), 32'h3, '1,
                      blinky_pkg::RESP_OKAY, "blink start");
      while (!led) begin
        @(negedge clk);
      end
      // first gap starts mid-interval and only aligns to a toggle
      measure_toggle_gap(gap);
      repeat (4) begin
        measure_toggle_gap(gap);
        check_data(DW'(gap), DW'(toggle + 2), "blink interval");
      end
    end
  endtask

  task automatic back_pressure();
    int                     toggle;
    int                     wait_cycles;
    logic [DW-1:0]          data;
    blinky_pkg::axil_resp_e resp;
    toggle = 8 + ($urandom % 33);
    axil_write(word_addr(blinky_pkg::REG_FLAGS), 32'h0, '1, 1 + ($urandom % 8), resp);
    check_resp(resp, blinky_pkg::RESP_OKAY, "stalled flags write");
    axil_write(word_addr(blinky_pkg::REG_CNT_TOGGLE), DW'(toggle), '1, 1 + ($urandom % 8), resp);
    check_resp(resp, blinky_pkg::RESP_OKAY, "stalled cnt_toggle write");
    axil_read(word_addr(blinky_pkg::REG_CNT_TOGGLE), 1 + ($urandom % 8), data, resp);
    check_resp(resp, blinky_pkg::RESP_OKAY, "stalled cnt_toggle read");
    check_data(data, DW'(toggle), "stalled cnt_toggle read");
    write_and_check(word_addr(blinky_pkg::REG_FLAGS), 32'h3, '1,
                    blinky_pkg::RESP_OKAY, "blink start");
    // a period of toggle + 2 cycles walks the count from 0 up to toggle + 1
    repeat (2) begin
      // sample at a random point of a later period
      wait_cycles = toggle + 2 + ($urandom % (toggle + 2));
      repeat (wait_cycles) begin
        @(negedge clk);
      end
      axil_read(word_addr(blinky_pkg::REG_CNT), 0, data, resp);
      check_resp(resp, blinky_pkg::RESP_OKAY, "counter read");
      num_checks++;
      if (data > DW'(toggle + 1)) begin
        num_errors++;
        $display("Mismatch at %0t: counter read %0d, above the bound %0d",
                 $time, data, toggle + 1);
      end
    end
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------

  initial begin
    void'($urandom(32'h7b91));
    clk        = 1'b0;
    rst_n      = 1'b0;
    awaddr     = '0;
    awvalid    = 1'b0;
    wdata      = '0;
    wstrb      = '0;
    wvalid     = 1'b0;
    bready     = 1'b1;
    araddr     = '0;
    arvalid    = 1'b0;
    rready     = 1'b1;
    num_checks = 0;
    num_errors = 0;
    cycles     = 0;
    exp_flags  = 2'b00;
    exp_toggle = DW'(RESET_TOGGLE);

    repeat (16) begin
      @(negedge clk);
    end
    rst_n = 1'b1;
    @(negedge clk);

    reset_values();
    register_readback();
    error_responses();
    solid_and_disable();
    blink_timing();
    back_pressure();

    $display("checks: %0d  errors: %0d", num_checks, num_errors);
    if (num_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* compile.f */
logic/blinky_pkg.sv
logic/skid_buffer.sv
logic/pipelined_accumulator.sv
logic/led_sequencer.sv
logic/blinky_regs.sv
logic/blinky_top.sv
verif/blinky_tb.sv
